//--- hw/core_pkg.sv
package core_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 16;

    // data memory geometry.
    localparam int dm_depth  = 256;
    localparam int dm_addr_w = 8;

    // writeback source select.
    localparam logic wb_sel_alu = 1'b0;
    localparam logic wb_sel_mem = 1'b1;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_lui  = 4'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        dm_none  = 3'd0,
        dm_word  = 3'd1,
        dm_half  = 3'd2,
        dm_halfu = 3'd3, // zero extended.
        dm_byte  = 3'd4,
        dm_byteu = 3'd5  // zero extended.
    } dm_op_e;

    // EX/MEM latch contents.
    typedef struct packed {
        logic [data_w-1:0]     alu_res;
        logic [data_w-1:0]     store_data;
        dm_op_e                dm_op;
        logic                  mem_write;
        logic                  mem_read;
        logic [reg_addr_w-1:0] dest_reg;
        logic                  reg_w_en;
        logic                  wb_sel;
    } ex_mem_t;

    // MEM/WB latch contents.
    typedef struct packed {
        logic [data_w-1:0]     wb_data;
        logic [reg_addr_w-1:0] dest_reg;
        logic                  reg_w_en;
    } mem_wb_t;

endpackage

//--- hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  core_pkg::alu_op_e                 alu_op,
    input  logic                              alu_src,
    input  logic                              issue,
    input  logic [core_pkg::data_w-1:0]       operand_a,
    input  logic [core_pkg::data_w-1:0]       operand_b,
    input  logic [core_pkg::imm_w-1:0]        imm16,
    input  core_pkg::dm_op_e                  dm_op,
    input  logic                              mem_write,
    input  logic                              mem_read,
    input  logic [core_pkg::reg_addr_w-1:0]   dest_reg,
    input  logic                              reg_w_en,
    input  logic                              wb_sel,
    output core_pkg::ex_mem_t                 payload
);

    localparam int ext_w = core_pkg::data_w - core_pkg::imm_w;

    logic                          zero_ext;
    logic [core_pkg::data_w-1:0]   imm_ext;
    logic [core_pkg::data_w-1:0]   op_b;
    logic [core_pkg::data_w-1:0]   alu_res;
    logic [core_pkg::data_w-1:0]   diff;

    // logical ops take the immediate unsigned.
    always_comb begin
        zero_ext = (alu_op == core_pkg::alu_and) ||
                   (alu_op == core_pkg::alu_or)  ||
                   (alu_op == core_pkg::alu_xor);
    end

    always_comb begin
        if (zero_ext) begin
            imm_ext = {{ext_w{1'b0}}, imm16};
        end else begin
            imm_ext = {{ext_w{imm16[core_pkg::imm_w-1]}}, imm16};
        end
        op_b = alu_src ? imm_ext : operand_b;
    end

    assign diff = operand_a - op_b;

    always_comb begin
        case (alu_op)
            core_pkg::alu_add: begin
                alu_res = operand_a + op_b;
            end
            core_pkg::alu_sub: begin
                alu_res = diff;
            end
            core_pkg::alu_and: begin
                alu_res = operand_a & op_b;
            end
            core_pkg::alu_or: begin
                alu_res = operand_a | op_b;
            end
            core_pkg::alu_xor: begin
                alu_res = operand_a ^ op_b;
            end
            core_pkg::alu_slt: begin
                alu_res = {{(core_pkg::data_w-1){1'b0}},
                           ($signed(operand_a) < $signed(op_b))};
            end
            core_pkg::alu_sltu: begin
                alu_res = {{(core_pkg::data_w-1){1'b0}}, (operand_a < op_b)};
            end
            core_pkg::alu_lui: begin
                alu_res = {imm16, {ext_w{1'b0}}}; // immediate in upper half.
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // no issue means a bubble.
    always_comb begin
        payload            = '0;
        payload.alu_res    = alu_res;
        payload.store_data = operand_b;
        payload.dm_op      = dm_op;
        payload.mem_write  = mem_write & issue;
        payload.mem_read   = mem_read;
        payload.dest_reg   = dest_reg;
        payload.reg_w_en   = reg_w_en & issue;
        payload.wb_sel     = wb_sel;
    end

endmodule

//--- hw/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // clear wins over en.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              en,
    input  core_pkg::ex_mem_t req,
    output core_pkg::mem_wb_t resp
);

    logic [core_pkg::data_w-1:0]    mem [core_pkg::dm_depth];

    logic [core_pkg::dm_addr_w-1:0] word_idx;
    logic [1:0]                     lane;
    logic [3:0]                     byte_en;
    logic [core_pkg::data_w-1:0]    wdata;
    logic [core_pkg::data_w-1:0]    rdata;
    logic [15:0]                    rd_half;
    logic [7:0]                     rd_byte;
    logic [core_pkg::data_w-1:0]    load_data;

    assign word_idx = req.alu_res[core_pkg::dm_addr_w+1:2];
    assign lane     = req.alu_res[1:0];

    // lane enables and replicated write data.
    always_comb begin
        byte_en = 4'b0000;
        wdata   = req.store_data;
        case (req.dm_op)
            core_pkg::dm_word: begin
                byte_en = 4'b1111;
            end
            core_pkg::dm_half,
            core_pkg::dm_halfu: begin
                byte_en = lane[1] ? 4'b1100 : 4'b0011; // bit 0 ignored.
                wdata   = {2{req.store_data[15:0]}};
            end
            core_pkg::dm_byte,
            core_pkg::dm_byteu: begin
                byte_en = 4'b0001 << lane;
                wdata   = {4{req.store_data[7:0]}};
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (en && req.mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    assign rdata   = mem[word_idx];
    assign rd_half = lane[1] ? rdata[31:16] : rdata[15:0];
    assign rd_byte = rdata[8*lane +: 8];

    // size and extend the read lane.
    always_comb begin
        case (req.dm_op)
            core_pkg::dm_word: begin
                load_data = rdata;
            end
            core_pkg::dm_half: begin
                load_data = {{16{rd_half[15]}}, rd_half};
            end
            core_pkg::dm_halfu: begin
                load_data = {16'b0, rd_half};
            end
            core_pkg::dm_byte: begin
                load_data = {{24{rd_byte[7]}}, rd_byte};
            end
            core_pkg::dm_byteu: begin
                load_data = {24'b0, rd_byte};
            end
            default: begin
                load_data = '0;
            end
        endcase
        if (!req.mem_read) begin
            load_data = '0; // no read, no data.
        end
    end

    always_comb begin
        resp          = '0;
        resp.dest_reg = req.dest_reg;
        resp.reg_w_en = req.reg_w_en;
        if (req.wb_sel == core_pkg::wb_sel_mem) begin
            resp.wb_data = load_data;
        end else begin
            resp.wb_data = req.alu_res;
        end
    end

endmodule

//--- hw/ex_mem_top.sv
`timescale 1ns/1ps

module ex_mem_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              issue,
    input  core_pkg::alu_op_e                 alu_op,
    input  logic                              alu_src,
    input  logic [core_pkg::data_w-1:0]       operand_a,
    input  logic [core_pkg::data_w-1:0]       operand_b,
    input  logic [core_pkg::imm_w-1:0]        imm16,
    input  core_pkg::dm_op_e                  dm_op,
    input  logic                              mem_write,
    input  logic                              mem_read,
    input  logic [core_pkg::reg_addr_w-1:0]   dest_reg,
    input  logic                              reg_w_en,
    input  logic                              wb_sel,
    input  logic                              stall,
    input  logic                              flush,
    output logic                              wb_w_en,
    output logic [core_pkg::reg_addr_w-1:0]   wb_reg,
    output logic [core_pkg::data_w-1:0]       wb_data
);

    logic              latch_en;
    core_pkg::ex_mem_t ex_out;
    core_pkg::ex_mem_t ex_mem_q;
    core_pkg::mem_wb_t mem_out;
    core_pkg::mem_wb_t mem_wb_q;

    assign latch_en = ~stall; // stall freezes both latches.

    ex_stage u_ex (
        .alu_op    (alu_op),
        .alu_src   (alu_src),
        .issue     (issue),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .imm16     (imm16),
        .dm_op     (dm_op),
        .mem_write (mem_write),
        .mem_read  (mem_read),
        .dest_reg  (dest_reg),
        .reg_w_en  (reg_w_en),
        .wb_sel    (wb_sel),
        .payload   (ex_out)
    );

    stage_reg #(.payload_t(core_pkg::ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (latch_en),
        .clear (flush),
        .d     (ex_out),
        .q     (ex_mem_q)
    );

    mem_stage u_mem (
        .clk  (clk),
        .en   (latch_en),
        .req  (ex_mem_q),
        .resp (mem_out)
    );

    stage_reg #(.payload_t(core_pkg::mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (latch_en),
        .clear (1'b0),
        .d     (mem_out),
        .q     (mem_wb_q)
    );

    assign wb_w_en = mem_wb_q.reg_w_en;
    assign wb_reg  = mem_wb_q.dest_reg;
    assign wb_data = mem_wb_q.wb_data;

endmodule

//--- tb/ex_mem_assert.sv
`timescale 1ns/1ps

module ex_mem_assert (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        stall,
    input logic                        flush,
    input logic                        wb_w_en,
    input logic [core_pkg::data_w-1:0] wb_data
);

    property reset_empty;
        @(posedge clk) !rst_n |=> !wb_w_en;
    endproperty

    // MEM/WB holds while stalled.
    property stall_holds;
        @(posedge clk) disable iff (!rst_n)
            stall |=> $stable(wb_data);
    endproperty

    // cleared EX/MEM slot reaches writeback as a bubble.
    property flush_bubble;
        @(posedge clk) disable iff (!rst_n)
            ($past(flush, 2) && !$past(stall)) |-> !wb_w_en;
    endproperty

    reset_a: assert property (reset_empty)
        else $error("wb_w_en high during reset");
    stall_a: assert property (stall_holds)
        else $error("wb_data changed under stall");
    flush_a: assert property (flush_bubble)
        else $error("writeback from a flushed slot");

endmodule

bind ex_mem_top ex_mem_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall   (stall),
    .flush   (flush),
    .wb_w_en (wb_w_en),
    .wb_data (wb_data)
);

//--- tb/ex_mem_tb.sv
`timescale 1ns/1ps

module ex_mem_tb;

    logic              clk;
    logic              rst_n;
    logic              issue;
    core_pkg::alu_op_e alu_op;
    logic              alu_src;
    logic [31:0]       operand_a;
    logic [31:0]       operand_b;
    logic [15:0]       imm16;
    core_pkg::dm_op_e  dm_op;
    logic              mem_write;
    logic              mem_read;
    logic [4:0]        dest_reg;
    logic              reg_w_en;
    logic              wb_sel;
    logic              stall;
    logic              flush;
    logic              wb_w_en;
    logic [4:0]        wb_reg;
    logic [31:0]       wb_data;

    logic [31:0] shadow [core_pkg::dm_depth]; // expected data memory.
    logic [31:0] seed = 32'h64f9;
    int          n_checks;
    int          n_errors;
    logic        issue_on;
    logic        flush_now;   // flush sampled with the instruction.
    logic        flush_next;  // flush one cycle later.
    logic        stall_next;

    ex_mem_top DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic [31:0] alu_model(input core_pkg::alu_op_e op, input logic src,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [15:0] imm);
        logic [31:0] y;
        if (!src) begin
            y = b;
        end else if (op inside {core_pkg::alu_and, core_pkg::alu_or, core_pkg::alu_xor}) begin
            y = {16'h0, imm};
        end else begin
            y = {{16{imm[15]}}, imm};
        end
        case (op)
            core_pkg::alu_add:  return a + y;
            core_pkg::alu_sub:  return a - y;
            core_pkg::alu_and:  return a & y;
            core_pkg::alu_or:   return a | y;
            core_pkg::alu_xor:  return a ^ y;
            core_pkg::alu_slt:  return {31'h0, $signed(a) < $signed(y)};
            core_pkg::alu_sltu: return {31'h0, a < y};
            default:            return {imm, 16'h0}; // lui.
        endcase
    endfunction

    task automatic shadow_store(input core_pkg::dm_op_e sz, input logic [31:0] addr,
                                input logic [31:0] data);
        logic [7:0] idx;
        idx = addr[9:2];
        case (sz)
            core_pkg::dm_word: shadow[idx] = data;
            core_pkg::dm_half, core_pkg::dm_halfu: shadow[idx][16*addr[1] +: 16] = data[15:0];
            core_pkg::dm_byte, core_pkg::dm_byteu: shadow[idx][8*addr[1:0] +: 8] = data[7:0];
            default: ;
        endcase
    endtask

    function automatic logic [31:0] load_model(input core_pkg::dm_op_e sz,
                                               input logic [31:0] addr);
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0]  b;
        w = shadow[addr[9:2]];
        h = w[16*addr[1] +: 16];
        b = w[8*addr[1:0] +: 8];
        case (sz)
            core_pkg::dm_word:  return w;
            core_pkg::dm_half:  return {{16{h[15]}}, h};
            core_pkg::dm_halfu: return {16'h0, h};
            core_pkg::dm_byte:  return {{24{b[7]}}, b};
            default:            return {24'h0, b}; // unsigned byte.
        endcase
    endfunction

    task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s = %h, expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic send(input core_pkg::alu_op_e op, input logic src, input logic [31:0] a,
                        input logic [31:0] b, input logic [15:0] imm, input core_pkg::dm_op_e dm,
                        input logic w, input logic r, input logic [4:0] dst, input logic ws);
        @(posedge clk);
        issue     <= issue_on;
        alu_op    <= op;
        alu_src   <= src;
        operand_a <= a;
        operand_b <= b;
        imm16     <= imm;
        dm_op     <= dm;
        mem_write <= w;
        mem_read  <= r;
        dest_reg  <= dst;
        reg_w_en  <= !w; // stores write no register.
        wb_sel    <= ws;
        flush     <= flush_now;
        @(posedge clk);
        issue     <= 1'b0;
        mem_write <= 1'b0;
        reg_w_en  <= 1'b0;
        flush     <= flush_next;
        stall     <= stall_next;
    endtask

    task automatic expect_wb(input logic [4:0] reg_exp, input logic [31:0] data_exp);
        int n;
        n = 0;
        while (n < 10) begin
            @(negedge clk);
            n++;
            if (wb_w_en) begin
                break;
            end
        end
        if (!wb_w_en) begin
            n_errors++;
            $display("Timeout at %0t: no writeback within %0d cycles", $time, n);
        end else begin
            check_val("wb latency", n, 2);
            check_val("wb_reg", 32'(wb_reg), 32'(reg_exp));
            check_val("wb_data", wb_data, data_exp);
        end
    endtask

    task automatic no_wb();
        int i;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_val("wb_w_en", 32'(wb_w_en), 32'h0);
        end
    endtask

    task automatic store(input core_pkg::dm_op_e sz, input logic [31:0] addr,
                         input logic [31:0] data);
        send(core_pkg::alu_add, 1'b1, addr, data, 16'h0, sz, 1'b1, 1'b0, 5'd0, 1'b0);
        shadow_store(sz, addr, data);
    endtask

    task automatic load(input core_pkg::dm_op_e sz, input logic [31:0] addr,
                        input logic [4:0] dst);
        send(core_pkg::alu_add, 1'b1, addr, 32'h0, 16'h0, sz, 1'b0, 1'b1, dst, 1'b1);
        expect_wb(dst, load_model(sz, addr));
    endtask

    task automatic hold_stall(input int cycles);
        logic [31:0] held;
        logic        held_en;
        logic [4:0]  held_reg;
        int          i;
        @(negedge clk);
        held     = wb_data;
        held_en  = wb_w_en;
        held_reg = wb_reg;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_val("wb_data", wb_data, held);
            check_val("wb_w_en", 32'(wb_w_en), 32'(held_en));
            check_val("wb_reg", 32'(wb_reg), 32'(held_reg));
        end
        @(posedge clk);
        stall <= 1'b0;
    endtask

    task automatic reset_bubbles();
        int i;
        no_wb();
        issue_on = 1'b0;
        for (i = 0; i < 3; i++) begin
            send(core_pkg::alu_add, 1'b0, xorshift32(), xorshift32(), 16'h0,
                 core_pkg::dm_none, 1'b0, 1'b0, 5'd3, 1'b0);
        end
        no_wb();
        issue_on = 1'b1;
    endtask

    task automatic alu_ops();
        int                i;
        core_pkg::alu_op_e op;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       r;
        logic [4:0]        dst;
        for (i = 0; i < 16; i++) begin
            op  = core_pkg::alu_op_e'(i >> 1);
            a   = xorshift32();
            b   = xorshift32();
            r   = xorshift32();
            dst = r[20:16];
            send(op, i[0], a, b, r[15:0], core_pkg::dm_none, 1'b0, 1'b0, dst, 1'b0);
            expect_wb(dst, alu_model(op, i[0], a, b, r[15:0]));
        end
    endtask

    task automatic mem_sizes();
        int          i;
        int          j;
        logic [31:0] addr;
        logic [31:0] r;
        for (i = 0; i < 8; i++) begin
            addr = xorshift32();
            store(core_pkg::dm_word, addr, xorshift32());
            r = xorshift32();
            store(core_pkg::dm_op_e'(i[0] ? 3'd2 : 3'd4), {addr[31:2], r[31:30]}, r);
            for (j = 1; j <= 5; j++) begin
                r = xorshift32();
                load(core_pkg::dm_op_e'(j), {addr[31:2], r[1:0]}, r[6:2]);
            end
        end
    endtask

    task automatic stall_resume();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        a    = xorshift32();
        b    = xorshift32();
        addr = xorshift32();
        stall_next = 1'b1;
        send(core_pkg::alu_add, 1'b0, a, b, 16'h0, core_pkg::dm_none, 1'b0, 1'b0, 5'd7, 1'b0);
        stall_next = 1'b0;
        hold_stall(4);
        expect_wb(5'd7, alu_model(core_pkg::alu_add, 1'b0, a, b, 16'h0));
        store(core_pkg::dm_word, addr, xorshift32());
        stall_next = 1'b1;
        store(core_pkg::dm_byte, addr, xorshift32()); // held in EX/MEM.
        stall_next = 1'b0;
        hold_stall(4);
        load(core_pkg::dm_word, addr, 5'd8);
    endtask

    task automatic flush_slot();
        logic [31:0] addr;
        addr = xorshift32();
        flush_now = 1'b1;
        send(core_pkg::alu_or, 1'b0, xorshift32(), xorshift32(), 16'h0,
             core_pkg::dm_none, 1'b0, 1'b0, 5'd9, 1'b0);
        flush_now = 1'b0;
        no_wb();
        store(core_pkg::dm_word, addr, xorshift32());
        flush_next = 1'b1;
        store(core_pkg::dm_half, addr, xorshift32()); // writes at the clearing edge.
        flush_next = 1'b0;
        load(core_pkg::dm_word, addr, 5'd10);
        load(core_pkg::dm_halfu, addr, 5'd11);
    endtask

    task automatic run_test(input int id, input string name);
        int e0;
        e0 = n_errors;
        case (id)
            0: reset_bubbles();
            1: alu_ops();
            2: mem_sizes();
            3: stall_resume();
            default: flush_slot();
        endcase
        $display("%s finished with %0d errors", name, n_errors - e0);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        issue = 1'b0;
        alu_op = core_pkg::alu_add;
        alu_src = 1'b0;
        operand_a = 32'h0;
        operand_b = 32'h0;
        imm16 = 16'h0;
        dm_op = core_pkg::dm_none;
        mem_write = 1'b0;
        mem_read = 1'b0;
        dest_reg = 5'd0;
        reg_w_en = 1'b0;
        wb_sel = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        n_checks = 0;
        n_errors = 0;
        issue_on = 1'b1;
        flush_now = 1'b0;
        flush_next = 1'b0;
        stall_next = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        run_test(0, "reset and bubbles");
        run_test(1, "alu ops");
        run_test(2, "loads and stores");
        run_test(3, "stall");
        run_test(4, "flush");
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/core_pkg.sv
hw/ex_stage.sv
hw/stage_reg.sv
hw/mem_stage.sv
hw/ex_mem_top.sv
tb/ex_mem_assert.sv
tb/ex_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ex_mem_tb -f vlog.f -o ex_mem_sim
./obj_dir/ex_mem_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation reported no failure"
